// ==== Bender.yml ====
package:
  name: irq_ctrl

export_include_dirs:
  - include

sources:
  - verilog/irq_pkg.sv
  - verilog/irq_priority_encoder.sv
  - verilog/irq_pending_regs.sv
  - verilog/irq_axil_regs.sv
  - verilog/irq_ctrl_top.sv
  - target: simulation
    files:
      - sim/irq_ctrl_tb.sv

// ==== project.f ====
+incdir+include
verilog/irq_pkg.sv
verilog/irq_priority_encoder.sv
verilog/irq_pending_regs.sv
verilog/irq_axil_regs.sv
verilog/irq_ctrl_top.sv
sim/irq_ctrl_tb.sv

// ==== sim/irq_ctrl_tb.sv ====
// Testbench for the interrupt controller
// Clock, reset, AXI4-Lite write and read tasks
// Reference model of pending and enable, response compare process
// Six directed and random tests, watchdog and summary

`timescale 1ns/1ns
`default_nettype none

module irq_ctrl_tb;

  import irq_pkg::*;

  localparam int clk_period  = 4;
  // Upper bound of bus transactions over all six tests
  localparam int planned_txn = 72;

  logic               clk;
  logic               rst_n;
  logic [num_irq-1:0] irq_src;
  axil_aw_t           aw;
  logic               awvalid;
  logic               awready;
  axil_w_t            w;
  logic               wvalid;
  logic               wready;
  axil_b_t            b;
  logic               bvalid;
  logic               bready;
  axil_ar_t           ar;
  logic               arvalid;
  logic               arready;
  axil_r_t            r;
  logic               rvalid;
  logic               rready;
  logic               irq;

  // Reference model state
  logic [num_irq-1:0] model_pending;
  logic [num_irq-1:0] model_enable;

  // Expected responses in issue order
  axil_r_t            exp_q[$];
  string              name_q[$];
  axil_resp_e         bresp_q[$];

  integer             seed = 25543;
  int                 err_cnt;
  int                 test_err_base;
  int                 test_cnt;
  int                 fail_cnt;
  int                 txn_cnt;
  logic [7:0]         src_a;
  logic [7:0]         src_b;
  logic [7:0]         en;
  logic [7:0]         sw;

  irq_ctrl_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //--------------------------------------------------
  // Reference model
  //--------------------------------------------------
  // Lowest set index of pending and enabled, valid in bit 3
  function automatic logic [3:0] expected_claim(input logic [7:0] pend, input logic [7:0] ena);
    logic [7:0] act;
    act            = pend & ena;
    expected_claim = 4'b0;
    // Walk downward so the last hit is the lowest index
    for (int i = num_irq - 1; i >= 0; i--) begin
      if (act[i]) expected_claim = {1'b1, 3'(i)};
    end
  endfunction

  //--------------------------------------------------
  // Bus tasks
  //--------------------------------------------------
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input axil_resp_e resp);
    bresp_q.push_back(resp);
    @(posedge clk);
    aw.addr <= addr;
    w.data  <= data;
    w.strb  <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge clk); while (!awready);
    // Transfer on this edge
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (resp == resp_okay && strb[0]) begin
      if (addr == reg_enable) model_enable = data[7:0];
      if (addr == reg_sw_set) model_pending = model_pending | data[7:0];
    end
    do @(negedge clk); while (!bvalid);
    txn_cnt++;
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] data,
                          input axil_resp_e resp, input string name);
    axil_r_t e;
    e.data = data;
    e.resp = resp;
    exp_q.push_back(e);
    name_q.push_back(name);
    @(posedge clk);
    ar.addr <= addr;
    arvalid <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    txn_cnt++;
  endtask

  // New level on the sources, pending settles two edges later
  task automatic drive_src(input logic [7:0] v);
    @(posedge clk);
    model_pending = model_pending | (v & ~irq_src);
    irq_src <= v;
    repeat (2) @(posedge clk);
  endtask

  // Claim until empty, each claim checked against the model
  task automatic drain_claims();
    logic [3:0] c;
    for (int n = 0; n <= num_irq; n++) begin
      c = expected_claim(model_pending, model_enable);
      read_reg(reg_claim, {c[3], 28'd0, c[2:0]}, resp_okay, "claim");
      if (!c[3]) break;
      model_pending[c[2:0]] = 1'b0;
    end
    check_irq();
  endtask

  task automatic check_irq();
    logic exp;
    exp = |(model_pending & model_enable);
    assert (irq === exp) else begin
      $display("Error: irq expected %h got %h", exp, irq);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  //--------------------------------------------------
  // Response compare
  //--------------------------------------------------
  always @(negedge clk) begin
    axil_r_t e;
    string   nm;
    if (rst_n && rvalid) begin
      if (exp_q.size() == 0) begin
        $display("Read response arrived with no read outstanding");
        err_cnt++;
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        assert (r.data === e.data) else begin
          $display("Error: r.data (%s) expected %h got %h", nm, e.data, r.data);
          err_cnt++;
        end
        assert (r.resp === e.resp) else begin
          $display("Error: r.resp (%s) expected %h got %h", nm, e.resp, r.resp);
          err_cnt++;
        end
      end
    end
    if (rst_n && bvalid) begin
      if (bresp_q.size() == 0) begin
        $display("Write response arrived with no write outstanding");
        err_cnt++;
      end else begin
        assert (b.resp === bresp_q[0]) else begin
          $display("Error: b.resp expected %h got %h", bresp_q[0], b.resp);
          err_cnt++;
        end
        void'(bresp_q.pop_front());
      end
    end
  end

  // Watchdog sized from the transaction count
  initial begin
    #(planned_txn * 200 * clk_period);
    $display("Timeout after %0d transactions, the bus stopped answering", txn_cnt);
    $display("Regression failed");
    $finish;
  end

  //--------------------------------------------------
  // Tests
  //--------------------------------------------------
  initial begin
    rst_n         = 1'b0;
    irq_src       = '0;
    aw            = '0;
    w             = '0;
    awvalid       = 1'b0;
    wvalid        = 1'b0;
    bready        = 1'b1;
    ar            = '0;
    arvalid       = 1'b0;
    rready        = 1'b1;
    model_pending = '0;
    model_enable  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // 1: reset values
    read_reg(reg_pending, 32'd0, resp_okay, "pending");
    read_reg(reg_enable, 32'd0, resp_okay, "enable");
    read_reg(reg_claim, 32'd0, resp_okay, "claim");
    check_irq();
    report_test("reset values");

    // 2: enable readback, byte 0 strobe gates the write
    for (int i = 0; i < 4; i++) begin
      en = $random(seed);
      write_reg(reg_enable, {24'd0, en}, 4'hF, resp_okay);
      read_reg(reg_enable, {24'd0, model_enable}, resp_okay, "enable");
    end
    write_reg(reg_enable, {24'd0, ~model_enable}, 4'b1110, resp_okay);
    read_reg(reg_enable, {24'd0, model_enable}, resp_okay, "enable");
    report_test("enable readback");

    // 3: source edges, held source is not set again
    src_a = $random(seed);
    src_b = $random(seed) | 8'h80;
    drive_src(src_a);
    drive_src(8'h00);
    drive_src(src_b);
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    write_reg(reg_enable, 32'hFF, 4'hF, resp_okay);
    check_irq();
    drain_claims();
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    drive_src(8'h00);
    drive_src(src_b);
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    drain_claims();
    drive_src(8'h00);
    report_test("source edges");

    // 4: claims in priority order
    en = $random(seed) | 8'h01;
    sw = $random(seed) | 8'h10;
    write_reg(reg_enable, {24'd0, en}, 4'hF, resp_okay);
    write_reg(reg_sw_set, {24'd0, sw}, 4'hF, resp_okay);
    check_irq();
    drain_claims();
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    // Leftover disabled bits cleared for the next test
    write_reg(reg_enable, 32'hFF, 4'hF, resp_okay);
    drain_claims();
    report_test("claim order");

    // 5: disabled software sets stay pending
    en = $random(seed) & 8'h7F;
    sw = ($random(seed) | 8'h80) & ~en;
    write_reg(reg_enable, {24'd0, en}, 4'hF, resp_okay);
    write_reg(reg_sw_set, {24'd0, sw}, 4'hF, resp_okay);
    check_irq();
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    drain_claims();
    write_reg(reg_enable, {24'd0, en | 8'h80}, 4'hF, resp_okay);
    check_irq();
    write_reg(reg_enable, {24'd0, en}, 4'hF, resp_okay);
    check_irq();
    report_test("disabled software set");

    // 6: wrong direction and unmapped offsets
    write_reg(reg_pending, 32'hFF, 4'hF, resp_slverr);
    write_reg(reg_claim, 32'hFF, 4'hF, resp_slverr);
    write_reg(4'h6, 32'hFF, 4'hF, resp_slverr);
    read_reg(reg_sw_set, 32'd0, resp_slverr, "sw_set");
    read_reg(4'h2, 32'd0, resp_slverr, "offset 0x2");
    read_reg(4'hE, 32'd0, resp_slverr, "offset 0xE");
    read_reg(reg_pending, {24'd0, model_pending}, resp_okay, "pending");
    read_reg(reg_enable, {24'd0, model_enable}, resp_okay, "enable");
    report_test("slave errors");

    $display("%0d tests, %0d failed, %0d errors, %0d transactions",
             test_cnt, fail_cnt, err_cnt, txn_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : irq_ctrl_tb

`default_nettype wire

// ==== verilog/irq_ctrl_top.sv ====
// Interrupt controller top level
// AXI4-Lite register slave and pending logic

`timescale 1ns/1ns
`default_nettype none

module irq_ctrl_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [irq_pkg::num_irq-1:0]  irq_src,
  input  irq_pkg::axil_aw_t            aw,
  input  logic                         awvalid,
  output logic                         awready,
  input  irq_pkg::axil_w_t             w,
  input  logic                         wvalid,
  output logic                         wready,
  output irq_pkg::axil_b_t             b,
  output logic                         bvalid,
  input  logic                         bready,
  input  irq_pkg::axil_ar_t            ar,
  input  logic                         arvalid,
  output logic                         arready,
  output irq_pkg::axil_r_t             r,
  output logic                         rvalid,
  input  logic                         rready,
  output logic                         irq
);

  import irq_pkg::*;

  // Register strobes and interrupt state between the two blocks
  logic               enable_we;
  logic [num_irq-1:0] enable_wdata;
  logic               sw_set_we;
  logic [num_irq-1:0] sw_set_wdata;
  logic               claim_take;
  logic [num_irq-1:0] pending;
  logic [num_irq-1:0] enable;
  claim_t             claim;

  irq_axil_regs i_axil_regs (.*);

  irq_pending_regs i_pending_regs (.*);

endmodule : irq_ctrl_top

`default_nettype wire

// ==== verilog/irq_axil_regs.sv ====
// AXI4-Lite slave of the interrupt controller
// Write and read channel FSMs, register decode
// Registered responses, write strobes and claim pulse

`timescale 1ns/1ns
`default_nettype none

`include "irq_asserts.svh"

module irq_axil_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  // Write address and data
  input  irq_pkg::axil_aw_t            aw,
  input  logic                         awvalid,
  output logic                         awready,
  input  irq_pkg::axil_w_t             w,
  input  logic                         wvalid,
  output logic                         wready,
  // Write response
  output irq_pkg::axil_b_t             b,
  output logic                         bvalid,
  input  logic                         bready,
  // Read address and data
  input  irq_pkg::axil_ar_t            ar,
  input  logic                         arvalid,
  output logic                         arready,
  output irq_pkg::axil_r_t             r,
  output logic                         rvalid,
  input  logic                         rready,
  // Interrupt state
  input  logic [irq_pkg::num_irq-1:0]  pending,
  input  logic [irq_pkg::num_irq-1:0]  enable,
  input  irq_pkg::claim_t              claim,
  output logic                         enable_we,
  output logic [irq_pkg::num_irq-1:0]  enable_wdata,
  output logic                         sw_set_we,
  output logic [irq_pkg::num_irq-1:0]  sw_set_wdata,
  output logic                         claim_take
);

  import irq_pkg::*;

  wr_state_e wr_state;
  rd_state_e rd_state;
  reg_addr_e wr_addr;
  reg_addr_e rd_addr;
  logic      wr_fire;
  logic      wr_ok;
  logic      rd_fire;
  axil_r_t   r_next;

  //--------------------------------------------------
  // Write channel
  //--------------------------------------------------
  assign wr_addr = reg_addr_e'(aw.addr);

  // Address and data accepted together while no response is outstanding
  assign wr_fire = awvalid && wvalid && (wr_state == wr_idle);
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == wr_resp);

  // Writable offsets only
  assign wr_ok = (wr_addr == reg_enable) || (wr_addr == reg_sw_set);

  // State lives in byte 0
  assign enable_we    = wr_fire && (wr_addr == reg_enable) && w.strb[0];
  assign sw_set_we    = wr_fire && (wr_addr == reg_sw_set) && w.strb[0];
  assign enable_wdata = w.data[num_irq-1:0];
  assign sw_set_wdata = w.data[num_irq-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= wr_idle;
    end else begin
      case (wr_state)
        wr_idle: if (wr_fire) wr_state <= wr_resp;
        wr_resp: if (bready) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.resp <= wr_ok ? resp_okay : resp_slverr;
    end
  end

  //--------------------------------------------------
  // Read channel
  //--------------------------------------------------
  assign rd_addr    = reg_addr_e'(ar.addr);
  assign arready    = (rd_state == rd_idle);
  assign rd_fire    = arvalid && arready;
  assign rvalid     = (rd_state == rd_resp);
  // Pending clears on the same edge the claim is captured
  assign claim_take = rd_fire && (rd_addr == reg_claim);

  // Read data mux where sw_set and holes give SLVERR
  always_comb begin
    r_next.data = '0;
    r_next.resp = resp_okay;
    case (rd_addr)
      reg_pending: r_next.data[num_irq-1:0] = pending;
      reg_enable:  r_next.data[num_irq-1:0] = enable;
      reg_claim: begin
        r_next.data[axil_data_w-1]  = claim.valid;
        r_next.data[irq_id_w-1:0]   = claim.id;
      end
      default: r_next.resp = resp_slverr;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: if (rd_fire) rd_state <= rd_resp;
        rd_resp: if (rready) rd_state <= rd_idle;
        default: rd_state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r <= r_next;
    end
  end

  // Responses hold under back-pressure
  `irq_assert(bvalid_hold_a, clk, rst_n, bvalid && !bready |=> bvalid && $stable(b))
  `irq_assert(rvalid_hold_a, clk, rst_n, rvalid && !rready |=> rvalid && $stable(r))
  // A state strobe belongs to a write that is answered with OKAY
  `irq_assert(we_in_transfer_a, clk, rst_n,
    (enable_we || sw_set_we) |=> bvalid && (b.resp == resp_okay))

endmodule : irq_axil_regs

`default_nettype wire

// ==== verilog/irq_pending_regs.sv ====
// Pending and enable state of the interrupt controller
// Rising-edge detection on the level sources
// Claim selection through the priority encoder, claim clear

`timescale 1ns/1ns
`default_nettype none

`include "irq_asserts.svh"

module irq_pending_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [irq_pkg::num_irq-1:0]  irq_src,
  input  logic                         enable_we,
  input  logic [irq_pkg::num_irq-1:0]  enable_wdata,
  input  logic                         sw_set_we,
  input  logic [irq_pkg::num_irq-1:0]  sw_set_wdata,
  input  logic                         claim_take,
  output logic [irq_pkg::num_irq-1:0]  pending,
  output logic [irq_pkg::num_irq-1:0]  enable,
  output irq_pkg::claim_t              claim,
  output logic                         irq
);

  import irq_pkg::*;

  logic [num_irq-1:0] src_q;
  logic [num_irq-1:0] set_vec;
  logic [num_irq-1:0] clr_vec;
  logic [num_irq-1:0] gnt;

  //--------------------------------------------------
  // Set and clear vectors
  //--------------------------------------------------
  // Low on the last edge, high now
  assign set_vec = (irq_src & ~src_q) | (sw_set_we ? sw_set_wdata : '0);

  // Only the granted source clears, and only on a valid claim
  assign clr_vec = (claim_take && claim.valid) ? gnt : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q   <= '0;
      pending <= '0;
      enable  <= '0;
    end else begin
      src_q <= irq_src;
      // Set takes priority over a same-cycle clear
      pending <= (pending & ~clr_vec) | set_vec;
      if (enable_we) begin
        enable <= enable_wdata;
      end
    end
  end

  //--------------------------------------------------
  // Claim selection
  //--------------------------------------------------
  irq_priority_encoder #(
    .num_req (num_irq)
  ) i_priority_encoder (
    .req (pending & enable),
    .gnt (gnt)
  );

  // One-hot grant to source index
  always_comb begin
    claim.valid = |gnt;
    claim.id    = '0;
    for (int i = 0; i < num_irq; i++) begin
      if (gnt[i]) begin
        claim.id = irq_id_w'(i);
      end
    end
  end

  assign irq = |(pending & enable);

  // Claimed source is gone on the next cycle unless it was set again
  `irq_assert(claim_clears_a, clk, rst_n,
    claim_take && claim.valid && !set_vec[claim.id] |=> !pending[$past(claim.id)])
  // Empty claim leaves pending untouched apart from new sets
  `irq_assert(empty_claim_harmless_a, clk, rst_n,
    claim_take && !claim.valid |=> pending == $past(pending | set_vec))
  `irq_assert(irq_matches_claim_a, clk, rst_n, irq == claim.valid)

endmodule : irq_pending_regs

`default_nettype wire

// ==== verilog/irq_priority_encoder.sv ====
// Fixed-priority request encoder
// Keeps only the lowest-index active request
// Elaboration check on width, one-hot checks on the grant

`timescale 1ns/1ns
`default_nettype none

`include "irq_asserts.svh"

module irq_priority_encoder #(
  // Two requesters or more
  parameter int num_req = 2
) (
  input  logic [num_req-1:0] req,
  output logic [num_req-1:0] gnt
);

  //--------------------------------------------------
  // Width check
  //--------------------------------------------------
  `irq_assert_static(num_req_min_two_a, num_req >= 2)

  //--------------------------------------------------
  // Encoder
  //--------------------------------------------------
  always_comb begin
    logic found;
    found = 1'b0;
    gnt   = '0;
    // Index 0 wins, scan upward
    for (int i = 0; i < num_req; i++) begin
      if (req[i] && !found) begin
        gnt[i] = 1'b1;
        found  = 1'b1;
      end
    end
    // Checked against the grant just computed, skipped while inputs are unknown
    if (!$isunknown(req)) begin
      assert ($onehot0(gnt)) else $error("gnt not one-hot-or-zero");
      assert (gnt[0] == req[0]) else $error("gnt[0] differs from req[0]");
      if (gnt[num_req-1]) begin
        assert (req[num_req-2:0] == '0) else $error("top grant with lower request");
      end
    end
  end

endmodule : irq_priority_encoder

`default_nettype wire

// ==== verilog/irq_pkg.sv ====
// Interrupt controller package
// Source count and index width, AXI4-Lite widths
// Register offsets, response codes, channel states
// Bus channel structs and the claim struct

`default_nettype none

package irq_pkg;

  // Sources and index
  localparam int num_irq  = 8;
  localparam int irq_id_w = 3;

  // AXI4-Lite bus widths
  localparam int axil_addr_w = 4;
  localparam int axil_data_w = 32;

  // Register map, byte offsets
  typedef enum logic [axil_addr_w-1:0] {
    reg_pending = 4'h0,  // read only
    reg_enable  = 4'h4,  // read/write
    reg_claim   = 4'h8,  // read clears the claimed source
    reg_sw_set  = 4'hC   // write only
  } reg_addr_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  // Channel payloads, handshakes travel beside them
  typedef struct packed {logic [axil_addr_w-1:0] addr;} axil_aw_t;
  typedef struct packed {logic [axil_addr_w-1:0] addr;} axil_ar_t;

  typedef struct packed {
    logic [axil_data_w-1:0]   data;
    logic [axil_data_w/8-1:0] strb;
  } axil_w_t;

  typedef struct packed {axil_resp_e resp;} axil_b_t;

  typedef struct packed {
    logic [axil_data_w-1:0] data;
    axil_resp_e             resp;
  } axil_r_t;

  // Winning source of the priority encoder
  typedef struct packed {
    logic                valid;
    logic [irq_id_w-1:0] id;
  } claim_t;

  typedef enum logic {wr_idle, wr_resp} wr_state_e;
  typedef enum logic {rd_idle, rd_resp} rd_state_e;

endpackage : irq_pkg

`default_nettype wire

// ==== include/irq_asserts.svh ====
// Assertion macros for the interrupt controller
// Elaboration-time parameter check
// Clocked concurrent check, disabled while in reset

`ifndef IRQ_ASSERTS_SVH
`define IRQ_ASSERTS_SVH

// Fails elaboration when the expression is false
`define irq_assert_static(name, expr) \
  if (!(expr)) begin : name \
    $error("Static check failed: name"); \
  end

// Property sampled on the rising clock edge, off during reset
`define irq_assert(name, clk, rst_n, prop) \
  name : assert property (@(posedge clk) disable iff (!rst_n) prop) \
    else $error("Assertion failed: name");

`endif
